// File: Bender.yml
package:
  name: crsubsystem

sources:
  - rtl/crPkg.sv
  - rtl/exPipe.sv
  - rtl/controlRegs.sv
  - rtl/trapUnit.sv
  - rtl/crSubsystem.sv
  - target: test
    files:
      - verif/crTb.sv

// File: list.f
rtl/crPkg.sv
rtl/exPipe.sv
rtl/controlRegs.sv
rtl/trapUnit.sv
rtl/crSubsystem.sv
verif/crTb.sv

// File: rtl/controlRegs.sv
`timescale 1ns/1ns

module controlRegs
#(
	parameter int addrWidth = 48
)
(
	input logic clock,
	input logic reset,
	input logic hold,
	input crPkg::crWriteS stage1,
	input crPkg::crWriteS stage2,
	input crPkg::crWriteS stage3,
	input logic ex1Flush,
	input logic ex2Flush,
	input logic ex3Flush,
	input logic [addrWidth-1:0] pc,
	input crPkg::crTrapUpdS trapUpd,
	input crPkg::crIdE readId,
	output logic [63:0] readValue,
	output logic [63:0] srOut,
	output logic [addrWidth-1:0] vbrOut,
	output logic [addrWidth-1:0] spcOut
);

	import crPkg::*;

	// 64-bit registers
	logic [63:0] srReg;
	logic [63:0] exsrReg;
	logic [63:0] lrReg;
	logic [63:0] teaReg;

	// address-width registers
	logic [addrWidth-1:0] spcReg;
	logic [addrWidth-1:0] sspReg;
	logic [addrWidth-1:0] vbrReg;
	logic [addrWidth-1:0] gbrReg;
	logic [addrWidth-1:0] tbrReg;

	logic commitValid;
	logic noForward;
	logic [63:0] storedValue;

	assign srOut = srReg;
	assign vbrOut = vbrReg;
	assign spcOut = spcReg;

	// value as it would land in the register, so forwarding matches commit
	function automatic logic [63:0] fitValue(input crIdE id, input logic [63:0] value);
		logic [63:0] fitted;
		fitted = value;
		case (id)
			SPC, SSP, VBR, GBR, TBR:
				fitted = 64'(value[addrWidth-1:0]);
			default:
				fitted = value;
		endcase
		return fitted;
	endfunction

	// stored view, address-width registers zero-extended
	always_comb
	begin
		case (readId)
			SR: storedValue = srReg;
			EXSR: storedValue = exsrReg;
			PC: storedValue = 64'(pc);
			LR: storedValue = lrReg;
			SPC: storedValue = 64'(spcReg);
			SSP: storedValue = 64'(sspReg);
			VBR: storedValue = 64'(vbrReg);
			GBR: storedValue = 64'(gbrReg);
			TBR: storedValue = 64'(tbrReg);
			TEA: storedValue = teaReg;
			default: storedValue = '0;
		endcase
	end

	// null ids read zero; PC always shows the live pc, never a pending write
	assign noForward = (readId == IMM) || (readId == ZZR) || (readId == PC);

	// oldest first, so the youngest matching stage overrides
	always_comb
	begin
		readValue = storedValue;
		if (!noForward && stage3.valid && !ex3Flush && stage3.id == readId)
			readValue = fitValue(stage3.id, stage3.value);
		if (!noForward && stage2.valid && !ex2Flush && stage2.id == readId)
			readValue = fitValue(stage2.id, stage2.value);
		if (!noForward && stage1.valid && !ex1Flush && stage1.id == readId)
			readValue = fitValue(stage1.id, stage1.value);
	end

	assign commitValid = stage3.valid && !ex3Flush;

	// ex3 commit beats a trap update to the same register
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			srReg <= srResetValue;
			exsrReg <= '0;
			lrReg <= '0;
			teaReg <= '0;
			spcReg <= '0;
			sspReg <= '0;
			vbrReg <= '0;
			gbrReg <= '0;
			tbrReg <= '0;
		end
		else if (!hold)
		begin
			if (commitValid && stage3.id == SR)
				srReg <= stage3.value;
			else if (trapUpd.srEn)
				srReg <= trapUpd.sr;

			if (commitValid && stage3.id == EXSR)
				exsrReg <= stage3.value;
			else if (trapUpd.exsrEn)
				exsrReg <= trapUpd.exsr;

			if (commitValid && stage3.id == SPC)
				spcReg <= stage3.value[addrWidth-1:0];
			else if (trapUpd.spcEn)
				spcReg <= trapUpd.spc[addrWidth-1:0];

			// the rest only change through the pipe
			if (commitValid)
			begin
				case (stage3.id)
					LR: lrReg <= stage3.value;
					TEA: teaReg <= stage3.value;
					SSP: sspReg <= stage3.value[addrWidth-1:0];
					VBR: vbrReg <= stage3.value[addrWidth-1:0];
					GBR: gbrReg <= stage3.value[addrWidth-1:0];
					TBR: tbrReg <= stage3.value[addrWidth-1:0];
					// PC and null ids drop the write
					default:
					begin
					end
				endcase
			end
		end
	end

	// whole register set frozen across a held edge
	holdFreezes: assert property (
		@(posedge clock) disable iff (reset)
		hold |=> $stable({srReg, exsrReg, lrReg, teaReg, spcReg, sspReg, vbrReg,
			gbrReg, tbrReg})
	);

	nullReadsZero: assert property (
		@(posedge clock) disable iff (reset)
		(readId == IMM || readId == ZZR) |-> readValue == '0
	);

endmodule

// File: rtl/crPkg.sv
package crPkg;

	// control register ids as they appear in the read port and write pipe
	typedef enum logic [4:0]
	{
		// status, 64 bits
		SR,
		// saved status and trap code, 64 bits
		EXSR,
		// reads the synthesized pc, never written here
		PC,
		// link register, 64 bits
		LR,
		// saved pc on trap entry, address width
		SPC,
		// saved stack pointer, address width
		SSP,
		// trap vector base, address width
		VBR,
		// global base, address width
		GBR,
		// thread base, address width
		TBR,
		// trap effective address, 64 bits
		TEA,
		// null ids, read as zero and drop writes
		IMM,
		ZZR
	} crIdE;

	// one pending result travelling down the execute stages
	typedef struct packed
	{
		logic valid;
		crIdE id;
		logic [63:0] value;
	} crWriteS;

	// next-state steering from the trap unit into the register file
	typedef struct packed
	{
		logic srEn;
		logic [63:0] sr;
		logic exsrEn;
		logic [63:0] exsr;
		logic spcEn;
		logic [63:0] spc;
	} crTrapUpdS;

	// interrupt-mode bit in SR
	localparam int unsigned srIsrBit = 28;

	// SR comes out of reset with bit 30 set
	localparam logic [63:0] srResetValue = 64'h0000_0000_4000_0000;

	// trap code to VBR offset, 8 bytes per vector
	localparam int unsigned trapVectorShift = 3;

endpackage

// File: rtl/crSubsystem.sv
`timescale 1ns/1ns

module crSubsystem
#(
	parameter int addrWidth = 48
)
(
	input logic clock,
	input logic reset,
	input logic hold,
	input crPkg::crWriteS issue,
	input logic ex1Flush,
	input logic ex2Flush,
	input logic ex3Flush,
	input logic [addrWidth-1:0] pc,
	input logic trapRequest,
	input logic [15:0] trapCode,
	input logic rteRequest,
	input crPkg::crIdE readId,
	output logic [63:0] readValue,
	output logic redirectValid,
	output logic [addrWidth-1:0] redirectPc,
	output logic [63:0] sr
);

	import crPkg::*;

	// pending writes per execute stage
	crWriteS stage1;
	crWriteS stage2;
	crWriteS stage3;

	// trap unit steering and the registers it looks at
	crTrapUpdS trapUpd;
	logic [addrWidth-1:0] vbr;
	logic [addrWidth-1:0] spc;

	exPipe pipe
	(
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.issue(issue),
		.ex1Flush(ex1Flush),
		.ex2Flush(ex2Flush),
		.stage1(stage1),
		.stage2(stage2),
		.stage3(stage3)
	);

	controlRegs #(.addrWidth(addrWidth)) regs
	(
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.stage1(stage1),
		.stage2(stage2),
		.stage3(stage3),
		.ex1Flush(ex1Flush),
		.ex2Flush(ex2Flush),
		.ex3Flush(ex3Flush),
		.pc(pc),
		.trapUpd(trapUpd),
		.readId(readId),
		.readValue(readValue),
		.srOut(sr),
		.vbrOut(vbr),
		.spcOut(spc)
	);

	trapUnit #(.addrWidth(addrWidth)) trap
	(
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.trapRequest(trapRequest),
		.trapCode(trapCode),
		.rteRequest(rteRequest),
		.pc(pc),
		.sr(sr),
		.vbr(vbr),
		.spc(spc),
		.trapUpd(trapUpd),
		.redirectValid(redirectValid),
		.redirectPc(redirectPc)
	);

endmodule

// File: rtl/exPipe.sv
`timescale 1ns/1ns

module exPipe
(
	input logic clock,
	input logic reset,
	input logic hold,
	input crPkg::crWriteS issue,
	input logic ex1Flush,
	input logic ex2Flush,
	output crPkg::crWriteS stage1,
	output crPkg::crWriteS stage2,
	output crPkg::crWriteS stage3
);

	import crPkg::*;

	// entries leaving a flushed stage move on as bubbles
	crWriteS next2;
	crWriteS next3;

	always_comb
	begin
		next2 = stage1;
		next2.valid = stage1.valid && !ex1Flush;
	end

	always_comb
	begin
		next3 = stage2;
		next3.valid = stage2.valid && !ex2Flush;
	end

	// ex3 flush is applied at commit, not here
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			stage1.valid <= 1'b0;
			stage2.valid <= 1'b0;
			stage3.valid <= 1'b0;
		end
		else if (!hold)
		begin
			stage1 <= issue;
			stage2 <= next2;
			stage3 <= next3;
		end
	end

	// a flushed stage never hands a live write to the next one
	ex1FlushKills: assert property (
		@(posedge clock) disable iff (reset)
		(!hold && ex1Flush) |=> !stage2.valid
	);

	ex2FlushKills: assert property (
		@(posedge clock) disable iff (reset)
		(!hold && ex2Flush) |=> !stage3.valid
	);

endmodule

// File: rtl/trapUnit.sv
`timescale 1ns/1ns

module trapUnit
#(
	parameter int addrWidth = 48
)
(
	input logic clock,
	input logic reset,
	input logic hold,
	input logic trapRequest,
	input logic [15:0] trapCode,
	input logic rteRequest,
	input logic [addrWidth-1:0] pc,
	input logic [63:0] sr,
	input logic [addrWidth-1:0] vbr,
	input logic [addrWidth-1:0] spc,
	output crPkg::crTrapUpdS trapUpd,
	output logic redirectValid,
	output logic [addrWidth-1:0] redirectPc
);

	import crPkg::*;

	typedef enum logic [1:0]
	{
		actIdle,
		actTrap,
		actReturn
	} trapActE;

	trapActE action;
	logic [addrWidth-1:0] vectorOffset;
	logic [addrWidth-1:0] redirectTarget;

	// trap wins if both ever show up, see assertion below
	always_comb
	begin
		if (trapRequest)
			action = actTrap;
		else if (rteRequest)
			action = actReturn;
		else
			action = actIdle;
	end

	// vector offset wraps at the address width
	assign vectorOffset = {{(addrWidth-16){1'b0}}, trapCode} << trapVectorShift;

	always_comb
	begin
		trapUpd = '0;
		trapUpd.sr = sr;
		// EXSR upper bits cleared on entry
		trapUpd.exsr = 64'(trapCode);
		trapUpd.spc = 64'(pc);
		redirectTarget = spc;
		case (action)
			actTrap:
			begin
				trapUpd.srEn = 1'b1;
				trapUpd.sr[srIsrBit] = 1'b1;
				trapUpd.exsrEn = 1'b1;
				trapUpd.spcEn = 1'b1;
				redirectTarget = vbr + vectorOffset;
			end
			actReturn:
			begin
				trapUpd.srEn = 1'b1;
				trapUpd.sr[srIsrBit] = 1'b0;
			end
			default:
			begin
			end
		endcase
	end

	// redirect shows up the cycle after the register update
	always_ff @(posedge clock)
	begin
		if (reset)
			redirectValid <= 1'b0;
		else if (!hold)
			redirectValid <= (action != actIdle);
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
			redirectPc <= redirectTarget;
	end

	trapRteExclusive: assert property (
		@(posedge clock) disable iff (reset)
		!(trapRequest && rteRequest)
	);

endmodule

// File: verif/crTb.sv
`timescale 1ns/1ns

module crTb;

	import crPkg::*;

	localparam int addrWidth = 48;
	localparam int cycleCount = 2000;
	localparam int waitLimit = 50;
	localparam logic [63:0] addrMask = (64'd1 << addrWidth) - 64'd1;

	logic clock;
	logic reset;
	logic hold;
	crWriteS issue;
	logic ex1Flush;
	logic ex2Flush;
	logic ex3Flush;
	logic [addrWidth-1:0] pc;
	logic trapRequest;
	logic [15:0] trapCode;
	logic rteRequest;
	crIdE readId;
	logic [63:0] readValue;
	logic redirectValid;
	logic [addrWidth-1:0] redirectPc;
	logic [63:0] sr;

	// reference model state
	logic [31:0] seed;
	logic [63:0] modelReg [0:11];
	crWriteS m1;
	crWriteS m2;
	crWriteS m3;
	logic modelRedirValid;
	logic [63:0] modelRedirPc;
	int waited;

	crSubsystem #(.addrWidth(addrWidth)) dut
	(
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.issue(issue),
		.ex1Flush(ex1Flush),
		.ex2Flush(ex2Flush),
		.ex3Flush(ex3Flush),
		.pc(pc),
		.trapRequest(trapRequest),
		.trapCode(trapCode),
		.rteRequest(rteRequest),
		.readId(readId),
		.readValue(readValue),
		.redirectValid(redirectValid),
		.redirectPc(redirectPc),
		.sr(sr)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#20 clock = ~clock;
	end

	// plain LCG, numerical recipes constants
	function automatic logic [31:0] nextRand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// low LCG bits are weak, take the upper ones
	function automatic int unsigned pick(input int unsigned range);
		return (nextRand() >> 8) % range;
	endfunction

	// what a register holds after a write of this value
	function automatic logic [63:0] landedValue(input crIdE id, input logic [63:0] value);
		logic [63:0] landed;
		if (id == SPC || id == SSP || id == VBR || id == GBR || id == TBR)
			landed = value & addrMask;
		else
			landed = value;
		return landed;
	endfunction

	// youngest live stage first, then the register array
	function automatic logic [63:0] expectedRead();
		logic [63:0] value;
		if (readId == IMM || readId == ZZR)
			value = '0;
		else if (readId == PC)
			value = 64'(pc);
		else if (m1.valid && !ex1Flush && m1.id == readId)
			value = landedValue(m1.id, m1.value);
		else if (m2.valid && !ex2Flush && m2.id == readId)
			value = landedValue(m2.id, m2.value);
		else if (m3.valid && !ex3Flush && m3.id == readId)
			value = landedValue(m3.id, m3.value);
		else
			value = modelReg[readId];
		return value;
	endfunction

	task automatic compareValue(input string testName, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected)
		begin
			$display("** Error %s: expected %h, actual %h", testName, expected, actual);
			$display(">>> FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// one random cycle of stimulus, applied on the falling edge
	task automatic driveRandom();
		int unsigned kind;
		hold = (pick(10) < 2);
		issue.valid = (pick(10) < 8);
		issue.id = crIdE'(pick(12));
		issue.value = {nextRand(), nextRand()};
		ex1Flush = (pick(10) == 0);
		ex2Flush = (pick(10) == 0);
		ex3Flush = (pick(10) == 0);
		pc = addrWidth'({nextRand(), nextRand()});
		// trap and rte each about one cycle in sixteen, never together
		kind = pick(32);
		trapRequest = (kind < 2);
		rteRequest = (kind == 2 || kind == 3);
		trapCode = 16'(nextRand() >> 8);
		readId = crIdE'(pick(12));
	endtask

	// everything observable before the rising edge
	task automatic checkCycle();
		compareValue($sformatf("read %s", readId.name()), expectedRead(), readValue);
		compareValue("sr output", modelReg[SR], sr);
		compareValue("redirect valid", 64'(modelRedirValid), 64'(redirectValid));
		if (modelRedirValid)
			compareValue("redirect pc", modelRedirPc, 64'(redirectPc));
	endtask

	// model update for the coming rising edge
	task automatic stepModel();
		logic [63:0] target;
		if (!hold)
		begin
			// targets come from pre-edge register values
			if (trapRequest)
				target = (modelReg[VBR] + ({48'b0, trapCode} << trapVectorShift)) & addrMask;
			else
				target = modelReg[SPC];
			if (trapRequest)
			begin
				modelReg[SR][srIsrBit] = 1'b1;
				modelReg[EXSR] = 64'(trapCode);
				modelReg[SPC] = 64'(pc);
			end
			else if (rteRequest)
				modelReg[SR][srIsrBit] = 1'b0;
			// ex3 commit lands on top of the trap update
			if (m3.valid && !ex3Flush)
			begin
				case (m3.id)
					SR, EXSR, LR, TEA, SPC, SSP, VBR, GBR, TBR:
						modelReg[m3.id] = landedValue(m3.id, m3.value);
					default:
					begin
					end
				endcase
			end
			m3 = m2;
			m3.valid = m2.valid && !ex2Flush;
			m2 = m1;
			m2.valid = m1.valid && !ex1Flush;
			m1 = issue;
			modelRedirValid = trapRequest || rteRequest;
			if (modelRedirValid)
				modelRedirPc = target;
		end
	endtask

	initial
	begin
		seed = 32'he751b672;
		reset = 1'b1;
		hold = 1'b0;
		issue = '0;
		ex1Flush = 1'b0;
		ex2Flush = 1'b0;
		ex3Flush = 1'b0;
		pc = '0;
		trapRequest = 1'b0;
		trapCode = '0;
		rteRequest = 1'b0;
		readId = SR;
		for (int i = 0; i < 12; i++)
			modelReg[i] = '0;
		modelReg[SR] = srResetValue;
		m1 = '0;
		m2 = '0;
		m3 = '0;
		modelRedirValid = 1'b0;
		modelRedirPc = '0;

		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// wait for the reset state to show
		waited = 0;
		while ((sr !== srResetValue || redirectValid !== 1'b0) && waited < waitLimit)
		begin
			@(negedge clock);
			waited++;
		end
		if (sr !== srResetValue || redirectValid !== 1'b0)
		begin
			$display("timed out waiting for the DUT to come out of reset");
			$display(">>> FAIL");
			$fatal(1, "reset timeout");
		end

		// sweep every id under hold, nothing moves
		hold = 1'b1;
		for (int i = 0; i < 12; i++)
		begin
			@(negedge clock);
			readId = crIdE'(i);
			pc = addrWidth'({nextRand(), nextRand()});
			#10;
			checkCycle();
			stepModel();
		end

		repeat (cycleCount)
		begin
			@(negedge clock);
			driveRandom();
			#10;
			checkCycle();
			stepModel();
		end

		$display(">>> PASS");
		$finish;
	end

endmodule
